// File: mmu_subsys.f
source/mmu_pkg.sv
source/lut_ram.sv
source/tlb_req_fifo.sv
source/tlb.sv
source/page_walker.sv
source/mmu_subsys.sv
tests/mmu_subsys_checker.sv
tests/mmu_subsys_tb.sv

// File: tests/mmu_subsys_tb.sv
// Testbench top for the MMU; applies a table of page table writes, mode changes and requests.
`timescale 1ns/1ps

module mmu_subsys_tb
    import mmu_pkg::*;
();

    localparam int WAYS           = 2;
    localparam int DEPTH          = 16;
    localparam int FIFO_DEPTH     = 4;
    localparam int CYCLES_PER_ROW = 40;  // Watchdog budget per table row.

    typedef enum logic [2:0] {OP_PTE, OP_MODE, OP_FLUSH, OP_DRAIN, OP_REQ} op_t;

    typedef struct packed {
        op_t                   op;
        logic [VADDR_W-1:0]    addr;       // Request address, table index or mode bit.
        logic [PPN_W-1:0]      ppn;
        logic [PTE_PERM_W-1:0] perm;       // Valid, read, write, execute.
        access_kind_t          kind;
        logic [VADDR_W-1:0]    exp_paddr;
        logic                  exp_fault;
        logic                  burst;      // No idle gap before this request.
    } row_t;

    logic clk = 1'b0;
    logic rst;
    logic tlb_on;
    logic flush;
    logic req_valid;
    logic req_credit;
    logic pt_write;
    logic [VADDR_W-1:0] req_vaddr;
    logic [VADDR_W-1:0] exp_paddr;
    logic [VADDR_W-1:0] resp_paddr;
    access_kind_t req_kind;
    logic [PT_INDEX_W-1:0] pt_index;
    logic [PPN_W-1:0] pt_ppn;
    logic [PTE_PERM_W-1:0] pt_perm;
    logic exp_fault;
    logic resp_valid;
    logic resp_fault;
    int value_errs;
    int proto_errs;
    int pending;
    int credit_total;
    int credits = FIFO_DEPTH;      // Credits the requester holds right now.
    int seq_errs = 0;
    logic [31:0] rng_state = 32'd92143;
    logic table_ready = 1'b0;
    row_t rows [$];

    mmu_subsys #(.WAYS(WAYS), .DEPTH(DEPTH), .FIFO_DEPTH(FIFO_DEPTH)) u_dut (
        .clk(clk), .rst(rst), .tlb_on(tlb_on), .flush(flush),
        .req_valid(req_valid), .req_vaddr(req_vaddr), .req_kind(req_kind),
        .req_credit(req_credit), .pt_write(pt_write), .pt_index(pt_index),
        .pt_ppn(pt_ppn), .pt_perm(pt_perm), .resp_valid(resp_valid),
        .resp_paddr(resp_paddr), .resp_fault(resp_fault)
    );

    mmu_subsys_checker #(.FIFO_DEPTH(FIFO_DEPTH)) u_checker (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_vaddr(req_vaddr),
        .exp_paddr(exp_paddr), .exp_fault(exp_fault), .req_credit(req_credit),
        .resp_valid(resp_valid), .resp_paddr(resp_paddr), .resp_fault(resp_fault),
        .value_errs(value_errs), .proto_errs(proto_errs), .pending(pending),
        .credit_total(credit_total)
    );

    initial begin
        forever #50 clk = ~clk;  // 100 ns period.
    end

    always @(negedge clk) begin
        if (!rst && req_credit) credits++;  // Each pulse hands one credit back.
    end

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic add_ctl(input op_t op, input logic [VADDR_W-1:0] arg,
                           input logic [PPN_W-1:0] ppn, input logic [PTE_PERM_W-1:0] perm);
        row_t r;
        r = '0;
        r.op = op;
        r.addr = arg;
        r.ppn = ppn;
        r.perm = perm;
        rows.push_back(r);
    endtask

    // The checker ignores the address of a faulting request.
    task automatic add_req(input logic [VADDR_W-1:0] vaddr, input access_kind_t kind,
                           input logic [VADDR_W-1:0] paddr, input logic fault, input logic burst);
        row_t r;
        r = '0;
        r.op = OP_REQ;
        r.addr = vaddr;
        r.kind = kind;
        r.exp_paddr = paddr;
        r.exp_fault = fault;
        r.burst = burst;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_ctl(OP_MODE, 0, 0, 0);                                // Translation off.
        add_req(32'h0000_1234, ACC_LOAD, 32'h0000_1234, 0, 0);
        add_req(32'hDEAD_BEEF, ACC_STORE, 32'hDEAD_BEEF, 0, 0);
        add_req(32'h0012_3456, ACC_FETCH, 32'h0012_3456, 0, 0);
        add_ctl(OP_PTE, 32'h05, 20'hABCDE, 4'b1111);
        add_ctl(OP_PTE, 32'h21, 20'h12345, 4'b1100);              // Read only.
        add_ctl(OP_PTE, 32'h07, 20'h55555, 4'b0111);              // Not valid.
        add_ctl(OP_PTE, 32'h15, 20'h0F0F0, 4'b1111);              // Same set as page 0x05.
        add_ctl(OP_PTE, 32'h23, 20'h77777, 4'b1111);
        add_ctl(OP_MODE, 1, 0, 0);
        add_req(32'h0000_5123, ACC_LOAD, 32'hABCD_E123, 0, 0);
        add_req(32'h0000_5FFC, ACC_STORE, 32'hABCD_EFFC, 0, 0);
        add_req(32'h0001_5010, ACC_FETCH, 32'h0F0F_0010, 0, 0);
        add_req(32'h0000_5004, ACC_FETCH, 32'hABCD_E004, 0, 0);
        add_req(32'h0002_1100, ACC_STORE, 0, 1, 0);
        add_req(32'h0002_1104, ACC_FETCH, 0, 1, 0);
        add_req(32'h0002_1108, ACC_LOAD, 32'h1234_5108, 0, 0);
        add_req(32'h0002_110C, ACC_STORE, 0, 1, 0);               // Now a hit, still no write.
        add_req(32'h0000_7000, ACC_LOAD, 0, 1, 0);
        add_req(32'h0001_0000, ACC_LOAD, 0, 1, 0);                // Never written.
        add_req(32'h0002_3ABC, ACC_LOAD, 32'h7777_7ABC, 0, 0);
        add_req(32'h0012_3ABC, ACC_LOAD, 0, 1, 0);                // VPN above the table.
        add_ctl(OP_PTE, 32'h05, 20'h3C3C3, 4'b1111);
        add_ctl(OP_FLUSH, 0, 0, 0);
        add_req(32'h0000_5ABC, ACC_LOAD, 32'h3C3C_3ABC, 0, 0);
        add_req(32'h0001_5ABC, ACC_FETCH, 32'h0F0F_0ABC, 0, 0);
        add_ctl(OP_DRAIN, 0, 0, 0);                               // Burst starts with all credits.
        add_req(32'h0000_5000, ACC_LOAD, 32'h3C3C_3000, 0, 1);
        add_req(32'h0002_1FFF, ACC_LOAD, 32'h1234_5FFF, 0, 1);
        add_req(32'h0001_5800, ACC_FETCH, 32'h0F0F_0800, 0, 1);
        add_req(32'h0000_7008, ACC_STORE, 0, 1, 1);
        add_ctl(OP_MODE, 0, 0, 0);
        add_req(32'h0000_5123, ACC_STORE, 32'h0000_5123, 0, 0);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;  // Inputs change just after the edge.
    endtask

    task automatic wait_quiet();
        while (pending != 0) next_cycle();  // Every response has been seen.
        if (credits != FIFO_DEPTH) begin  // A credit returns no later than its response.
            $display("Requester holds %0d credits with no request open, expected %0d.",
                     credits, FIFO_DEPTH);
            seq_errs++;
        end
    endtask

    task automatic apply_row(input row_t r);
        int gap;
        if (r.op != OP_REQ) wait_quiet();  // Control rows act only on an idle DUT.
        case (r.op)
            OP_PTE: begin
                pt_write = 1'b1;
                pt_index = r.addr[PT_INDEX_W-1:0];
                pt_ppn   = r.ppn;
                pt_perm  = r.perm;
                next_cycle();
                pt_write = 1'b0;
            end
            OP_MODE: begin
                tlb_on = r.addr[0];
                next_cycle();
            end
            OP_FLUSH: begin
                flush = 1'b1;
                next_cycle();
                flush = 1'b0;
            end
            OP_DRAIN: begin
            end
            default: begin
                gap = r.burst ? 0 : int'(xorshift() % 4);
                repeat (gap) next_cycle();
                while (credits == 0) next_cycle();
                req_valid = 1'b1;
                req_vaddr = r.addr;
                req_kind  = r.kind;
                exp_paddr = r.exp_paddr;
                exp_fault = r.exp_fault;
                credits--;
                next_cycle();
                req_valid = 1'b0;
            end
        endcase
    endtask

    task automatic print_counts();
        $display("Errors: value %0d, protocol %0d, sequence %0d",
                 value_errs, proto_errs, seq_errs);
    endtask

    initial begin
        rst = 1'b1;
        tlb_on = 1'b0;
        flush = 1'b0;
        req_valid = 1'b0;
        req_vaddr = '0;
        req_kind = ACC_LOAD;
        pt_write = 1'b0;
        pt_index = '0;
        pt_ppn = '0;
        pt_perm = '0;
        exp_paddr = '0;
        exp_fault = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        foreach (rows[i]) apply_row(rows[i]);
        wait_quiet();
        print_counts();
        if (value_errs == 0 && proto_errs == 0 && seq_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (rows.size() * CYCLES_PER_ROW) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles.",
                 rows.size() * CYCLES_PER_ROW);
        print_counts();
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: tests/mmu_subsys_checker.sv
// Testbench checker that matches each DUT response to the expected result and tracks credits.
`timescale 1ns/1ps

module mmu_subsys_checker
    import mmu_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  logic [VADDR_W-1:0] req_vaddr,
    input  logic [VADDR_W-1:0] exp_paddr,   // Expected result, driven together with the request.
    input  logic               exp_fault,
    input  logic               req_credit,
    input  logic               resp_valid,
    input  logic [VADDR_W-1:0] resp_paddr,
    input  logic               resp_fault,
    output int                 value_errs,
    output int                 proto_errs,
    output int                 pending,      // Requests still waiting for their response.
    output int                 credit_total  // Credit pulses seen since reset.
);

    logic [VADDR_W-1:0] q_vaddr [$];
    logic [VADDR_W-1:0] q_paddr [$];
    logic               q_fault [$];
    int                 sent;
    logic [VADDR_W-1:0] head_vaddr;
    logic [VADDR_W-1:0] head_paddr;
    logic               head_fault;

    // Sampled at the falling edge, half a cycle away from every DUT and stimulus change.
    always @(negedge clk) begin
        if (rst) begin
            q_vaddr.delete();
            q_paddr.delete();
            q_fault.delete();
            sent         = 0;
            value_errs   = 0;
            proto_errs   = 0;
            credit_total = 0;
        end else begin
            if (req_valid) begin
                q_vaddr.push_back(req_vaddr);  // Responses leave in request order.
                q_paddr.push_back(exp_paddr);
                q_fault.push_back(exp_fault);
                sent++;
            end
            if (req_credit) begin
                credit_total++;
                if (credit_total > sent) begin  // The requester would hold more than FIFO_DEPTH.
                    $display("Credit count rose above %0d at %0t.", FIFO_DEPTH, $time);
                    proto_errs++;
                end
            end
            if (resp_valid) begin
                if (q_paddr.size() == 0) begin
                    $display("Response 0x%08h at %0t arrived with no request waiting.",
                             resp_paddr, $time);
                    proto_errs++;
                end else begin
                    head_vaddr = q_vaddr.pop_front();
                    head_paddr = q_paddr.pop_front();
                    head_fault = q_fault.pop_front();
                    if (resp_fault !== head_fault) begin
                        $display("ERR resp_fault for vaddr 0x%08h: got 0x%0h, expected 0x%0h",
                                 head_vaddr, resp_fault, head_fault);
                        value_errs++;
                    end
                    // The address carries no meaning once a request faults.
                    if (!head_fault && resp_paddr !== head_paddr) begin
                        $display("ERR resp_paddr for vaddr 0x%08h: got 0x%08h, expected 0x%08h",
                                 head_vaddr, resp_paddr, head_paddr);
                        value_errs++;
                    end
                end
            end
        end
        pending = q_paddr.size();
    end

endmodule

// File: source/mmu_subsys.sv
// Top level of the MMU that joins the request FIFO, the TLB and the page walker.
`timescale 1ns/1ps

module mmu_subsys
    import mmu_pkg::*;
#(
    parameter int WAYS       = 2,
    parameter int DEPTH      = 16,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tlb_on,
    input  logic                  flush,
    input  logic                  req_valid,
    input  logic [VADDR_W-1:0]    req_vaddr,
    input  access_kind_t          req_kind,
    output logic                  req_credit,
    input  logic                  pt_write,
    input  logic [PT_INDEX_W-1:0] pt_index,
    input  logic [PPN_W-1:0]      pt_ppn,
    input  logic [PTE_PERM_W-1:0] pt_perm,
    output logic                  resp_valid,
    output logic [VADDR_W-1:0]    resp_paddr,
    output logic                  resp_fault
);

    logic                 fifo_valid;
    logic [VADDR_W-1:0]   fifo_vaddr;
    access_kind_t         fifo_kind;
    logic                 fifo_pop;
    logic                 walk_req;
    logic [VPN_W-1:0]     walk_vpn;
    access_kind_t         walk_kind;
    logic                 walk_done;
    logic [PPN_W-1:0]     walk_ppn;
    logic [PTE_RWX_W-1:0] walk_perm;
    logic                 walk_fault;

    tlb_req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_req_fifo (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_vaddr  (req_vaddr),
        .req_kind   (req_kind),
        .pop        (fifo_pop),
        .head_valid (fifo_valid),
        .head_vaddr (fifo_vaddr),
        .head_kind  (fifo_kind),
        .credit     (req_credit)
    );

    tlb #(
        .WAYS  (WAYS),
        .DEPTH (DEPTH)
    ) u_tlb (
        .clk        (clk),
        .rst        (rst),
        .tlb_on     (tlb_on),
        .flush      (flush),
        .fifo_valid (fifo_valid),
        .fifo_vaddr (fifo_vaddr),
        .fifo_kind  (fifo_kind),
        .fifo_pop   (fifo_pop),
        .walk_req   (walk_req),
        .walk_vpn   (walk_vpn),
        .walk_kind  (walk_kind),
        .walk_done  (walk_done),
        .walk_ppn   (walk_ppn),
        .walk_perm  (walk_perm),
        .walk_fault (walk_fault),
        .resp_valid (resp_valid),
        .resp_paddr (resp_paddr),
        .resp_fault (resp_fault)
    );

    page_walker u_walker (
        .clk        (clk),
        .rst        (rst),
        .pt_write   (pt_write),
        .pt_index   (pt_index),
        .pt_ppn     (pt_ppn),
        .pt_perm    (pt_perm),
        .walk_req   (walk_req),
        .walk_vpn   (walk_vpn),
        .walk_kind  (walk_kind),
        .walk_done  (walk_done),
        .walk_ppn   (walk_ppn),
        .walk_perm  (walk_perm),
        .walk_fault (walk_fault)
    );

endmodule

// File: source/page_walker.sv
// Flat page table and the walk FSM that answers TLB misses with a PPN or a fault.
`timescale 1ns/1ps

module page_walker
    import mmu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pt_write,
    input  logic [PT_INDEX_W-1:0] pt_index,
    input  logic [PPN_W-1:0]      pt_ppn,
    input  logic [PTE_PERM_W-1:0] pt_perm,
    input  logic                  walk_req,
    input  logic [VPN_W-1:0]      walk_vpn,
    input  access_kind_t          walk_kind,
    output logic                  walk_done,
    output logic [PPN_W-1:0]      walk_ppn,
    output logic [PTE_RWX_W-1:0]  walk_perm,
    output logic                  walk_fault
);

    localparam int PT_DEPTH = 2 ** PT_INDEX_W;

    logic [PPN_W-1:0]      ppn_mem [PT_DEPTH];
    logic [PTE_RWX_W-1:0]  rwx_mem [PT_DEPTH];
    logic [PT_DEPTH-1:0]   pt_valid;  // Kept apart from the arrays so reset can clear it.
    walk_state_t           state;
    logic [PT_INDEX_W-1:0] idx;
    logic                  out_of_range;
    logic                  entry_ok;

    assign idx          = walk_vpn[PT_INDEX_W-1:0];
    assign out_of_range = |walk_vpn[VPN_W-1:PT_INDEX_W];  // VPN beyond the last table entry.
    assign entry_ok     = !out_of_range && pt_valid[idx];  // The TLB checks the permissions.

    always_ff @(posedge clk) begin
        if (pt_write) begin
            ppn_mem[pt_index] <= pt_ppn;
            rwx_mem[pt_index] <= pt_perm[PTE_RWX_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pt_valid <= '0;
        end else if (pt_write) begin
            pt_valid[pt_index] <= pt_perm[PTE_V];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WALK_IDLE;
        end else begin
            case (state)
                WALK_IDLE:  state <= walk_req ? WALK_READ : WALK_IDLE;
                WALK_READ:  state <= WALK_REPLY;  // The table is read in this single cycle.
                WALK_REPLY: state <= WALK_IDLE;   // The TLB drops walk_req at this edge.
                default:    state <= WALK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WALK_READ) begin
            walk_ppn   <= ppn_mem[idx];
            walk_perm  <= rwx_mem[idx];
            walk_fault <= !entry_ok;
        end
    end

    assign walk_done = (state == WALK_REPLY);  // Two cycles after walk_req is first seen.

endmodule

// File: source/tlb.sv
// Set-associative TLB with round-robin fill, permission check, walker hand-off and set-by-set flush.
`timescale 1ns/1ps

module tlb
    import mmu_pkg::*;
#(
    parameter int WAYS  = 2,
    parameter int DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tlb_on,
    input  logic                 flush,
    input  logic                 fifo_valid,
    input  logic [VADDR_W-1:0]   fifo_vaddr,
    input  access_kind_t         fifo_kind,
    output logic                 fifo_pop,
    output logic                 walk_req,
    output logic [VPN_W-1:0]     walk_vpn,
    output access_kind_t         walk_kind,
    input  logic                 walk_done,
    input  logic [PPN_W-1:0]     walk_ppn,
    input  logic [PTE_RWX_W-1:0] walk_perm,
    input  logic                 walk_fault,
    output logic                 resp_valid,
    output logic [VADDR_W-1:0]   resp_paddr,
    output logic                 resp_fault
);

    localparam int SET_W = $clog2(DEPTH);  // Set index sits just above the page offset.
    localparam int TAG_W = VPN_W - SET_W;  // The rest of the VPN forms the tag.

    typedef struct packed {
        logic                 valid;
        logic [TAG_W-1:0]     tag;
        logic [PPN_W-1:0]     ppn;
        logic [PTE_RWX_W-1:0] rwx;
    } tlb_entry_t;

    tlb_state_t           state;
    logic                 flush_pending;  // Set by a flush pulse and held until the sweep starts.
    logic [SET_W-1:0]     flush_cnt;
    logic [WAYS-1:0]      victim_way;     // One-hot fill pointer.
    logic [VADDR_W-1:0]   req_vaddr;      // Request currently being translated.
    access_kind_t         req_kind;
    logic [VADDR_W-1:0]   look_vaddr;
    access_kind_t         look_kind;
    logic [SET_W-1:0]     look_set;
    logic [TAG_W-1:0]     look_tag;
    tlb_entry_t           way_entry [WAYS];
    logic [WAYS-1:0]      tag_hit;
    logic                 hit;
    logic [PPN_W-1:0]     hit_ppn;
    logic [PTE_RWX_W-1:0] hit_rwx;
    logic                 look_go;
    logic                 miss;
    logic                 fill;
    logic                 flushing;
    logic [WAYS-1:0]      way_we;
    logic [SET_W-1:0]     wr_set;
    tlb_entry_t           new_entry;

    // A new request is looked up straight from the FIFO head; a retry uses the held copy.
    assign look_vaddr = (state == TLB_IDLE) ? fifo_vaddr : req_vaddr;
    assign look_kind  = (state == TLB_IDLE) ? fifo_kind : req_kind;
    assign look_set   = look_vaddr[PAGE_OFF_W +: SET_W];
    assign look_tag   = look_vaddr[VADDR_W-1 -: TAG_W];

    for (genvar g = 0; g < WAYS; g++) begin : g_way
        lut_ram #(
            .WIDTH ($bits(tlb_entry_t)),
            .DEPTH (DEPTH)
        ) u_way_ram (
            .clk   (clk),
            .we    (way_we[g]),
            .waddr (wr_set),
            .wdata (new_entry),
            .raddr (look_set),
            .rdata (way_entry[g])
        );
    end

    always_comb begin
        hit_ppn = '0;
        hit_rwx = '0;
        for (int i = 0; i < WAYS; i++) begin
            tag_hit[i] = way_entry[i].valid && (way_entry[i].tag == look_tag);
            if (tag_hit[i]) begin
                hit_ppn = way_entry[i].ppn;  // At most one way holds a given tag.
                hit_rwx = way_entry[i].rwx;
            end
        end
    end

    assign hit       = |tag_hit;
    assign fifo_pop  = (state == TLB_IDLE) && fifo_valid && !flush_pending;
    assign look_go   = fifo_pop || (state == TLB_LOOKUP);
    assign miss      = look_go && tlb_on && !hit;  // Translation off never misses.
    assign fill      = (state == TLB_WALK) && walk_done && !walk_fault;
    assign flushing  = (state == TLB_FLUSH);
    assign way_we    = flushing ? {WAYS{1'b1}} : (fill ? victim_way : '0);
    assign wr_set    = flushing ? flush_cnt : req_vaddr[PAGE_OFF_W +: SET_W];
    assign new_entry = '{valid: !flushing,
                         tag:   req_vaddr[VADDR_W-1 -: TAG_W],
                         ppn:   walk_ppn,
                         rwx:   walk_perm};  // A flush writes the entry invalid.

    assign walk_vpn  = req_vaddr[VADDR_W-1 -: VPN_W];
    assign walk_kind = req_kind;

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            req_vaddr <= fifo_vaddr;  // Kept for the walk and the retry.
            req_kind  <= fifo_kind;
        end
    end

    always_ff @(posedge clk) begin
        if (look_go) begin
            if (!tlb_on) begin
                resp_paddr <= look_vaddr;  // Pass-through mode.
                resp_fault <= 1'b0;
            end else begin
                resp_paddr <= {hit_ppn, look_vaddr[PAGE_OFF_W-1:0]};
                resp_fault <= !perm_allows(hit_rwx, look_kind);
            end
        end else if (walk_done && walk_fault) begin
            resp_paddr <= req_vaddr;  // No translation exists so the virtual address is echoed.
            resp_fault <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= TLB_IDLE;
            flush_pending <= 1'b1;  // RAM contents are unknown after power-up so clear them first.
            flush_cnt     <= '0;
            victim_way    <= WAYS'(1);
            walk_req      <= 1'b0;
            resp_valid    <= 1'b0;
        end else begin
            victim_way <= (victim_way << 1) | (victim_way >> (WAYS - 1));  // Rotates every cycle.
            resp_valid <= (look_go && !miss) || (state == TLB_WALK && walk_done && walk_fault);
            if (flush) begin
                flush_pending <= 1'b1;
            end
            if (miss) begin
                walk_req <= 1'b1;  // Held until the walker answers.
            end else if (walk_done) begin
                walk_req <= 1'b0;
            end
            case (state)
                TLB_IDLE: begin
                    if (flush_pending) begin
                        state         <= TLB_FLUSH;
                        flush_pending <= flush;  // A pulse arriving now starts another sweep.
                        flush_cnt     <= '0;
                    end else if (miss) begin
                        state <= TLB_WALK;
                    end
                end
                TLB_LOOKUP: begin
                    state <= miss ? TLB_WALK : TLB_IDLE;
                end
                TLB_WALK: begin
                    if (walk_done) begin
                        state <= walk_fault ? TLB_IDLE : TLB_LOOKUP;  // Retry after a fill.
                    end
                end
                TLB_FLUSH: begin
                    flush_cnt <= flush_cnt + 1'b1;
                    if (flush_cnt == SET_W'(DEPTH - 1)) begin
                        state <= TLB_IDLE;  // Exactly DEPTH cycles in this state.
                    end
                end
                default: begin
                    state <= TLB_IDLE;
                end
            endcase
        end
    end

endmodule

// File: source/tlb_req_fifo.sv
// Translation request FIFO between the credit-based request ports and the TLB.
`timescale 1ns/1ps

module tlb_req_fifo
    import mmu_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  logic [VADDR_W-1:0] req_vaddr,
    input  access_kind_t       req_kind,
    input  logic               pop,
    output logic               head_valid,
    output logic [VADDR_W-1:0] head_vaddr,
    output access_kind_t       head_kind,
    output logic               credit
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);  // Counts from zero up to full.

    logic [VADDR_W-1:0] vaddr_mem [FIFO_DEPTH];
    access_kind_t       kind_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;

    // Pointers wrap explicitly so a depth that is not a power of two also works.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (req_valid) begin
            vaddr_mem[wr_ptr] <= req_vaddr;  // The requester never sends without a credit.
            kind_mem[wr_ptr]  <= req_kind;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= pop;  // Each popped entry frees one slot for the requester.
            if (req_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(req_valid) - CNT_W'(pop);
        end
    end

    assign head_valid = (count != '0);   // A write at one edge is visible right after it.
    assign head_vaddr = vaddr_mem[rd_ptr];
    assign head_kind  = kind_mem[rd_ptr];

endmodule

// File: source/lut_ram.sv
// Memory with one registered write port and a combinational read port; the TLB uses one per way.
`timescale 1ns/1ps

module lut_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];  // Small enough to map onto distributed LUT RAM.

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;  // Written data is readable from the next cycle on.
        end
    end

    assign rdata = mem[raddr];  // Asynchronous read so a lookup completes in one cycle.

endmodule

// File: source/mmu_pkg.sv
// Shared widths, enums and page table entry fields of the MMU; modules take them by wildcard import.
package mmu_pkg;

    localparam int VADDR_W    = 32;  // Virtual and physical addresses have the same width.
    localparam int PAGE_OFF_W = 12;  // 4 KiB pages.
    localparam int VPN_W      = 20;  // Virtual page number above the page offset.
    localparam int PPN_W      = 20;  // Physical page number stored in each entry.
    localparam int PT_INDEX_W = 8;   // The flat page table holds 256 entries.

    // Page table entry permission field as written through pt_perm.
    localparam int PTE_PERM_W = 4;  // Valid, read, write and execute.
    localparam int PTE_RWX_W  = 3;  // The TLB keeps only read, write and execute.
    localparam int PTE_V      = 3;  // Entry is present.
    localparam int PTE_R      = 2;  // Loads allowed.
    localparam int PTE_W      = 1;  // Stores allowed.
    localparam int PTE_X      = 0;  // Instruction fetches allowed.

    typedef enum logic [1:0] {
        ACC_LOAD,
        ACC_STORE,
        ACC_FETCH
    } access_kind_t;

    typedef enum logic [1:0] {
        TLB_IDLE,    // Waiting for a request or a pending flush.
        TLB_LOOKUP,  // Lookup retried after a fill.
        TLB_WALK,    // Waiting for the page walker.
        TLB_FLUSH    // Clearing one set per cycle.
    } tlb_state_t;

    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_READ,
        WALK_REPLY
    } walk_state_t;

    // True when the read, write and execute bits permit the given access kind.
    function automatic logic perm_allows(input logic [PTE_RWX_W-1:0] rwx,
                                         input access_kind_t kind);
        logic ok;
        case (kind)
            ACC_LOAD:  ok = rwx[PTE_R];
            ACC_STORE: ok = rwx[PTE_W];
            ACC_FETCH: ok = rwx[PTE_X];
            default:   ok = 1'b0;  // The unused encoding never grants access.
        endcase
        return ok;
    endfunction

endpackage
